// ==== common/gcrRxPkg.sv ====
`default_nettype none

package gcrRxPkg;

	// ====================
	// widths
	localparam int SYM_W = 5;			// one line symbol
	localparam int NYB_W = 4;			// decoded nybble
	localparam int WORD_W = 128;		// payload word
	localparam int CNT_W = 9;			// baud tick counter
	localparam int FRAME_SYMS = 36;	// symbols per frame incl. start/spares/stop

	// frame timing, in baud ticks
	localparam logic [1:0] SAMPLE_PHASE = 2'd1;
	localparam logic [CNT_W-1:0] END_TICK = 9'd142;	// stop code judged here
	localparam logic [CNT_W-1:0] LAST_TICK = 9'd143;	// back to idle
	localparam logic [SYM_W-1:0] START_SYM = 5'h0A;
	localparam logic [SYM_W-1:0] STOP_SYM = 5'h15;
	localparam int SYNC_STAGES = 4;

	// ====================
	// fifo and bus
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_CNT_W = 5;
	localparam logic [FIFO_CNT_W-1:0] FIFO_LIMIT = 5'd31;	// frame end refused at this count
	localparam int ACK_DELAY = 3;

	typedef enum logic {
		RX_IDLE,	// hunting for start code
		RX_COUNT	// frame in progress
	} rxState_e;

	// 4b/5b group code, indexed by nybble
	localparam logic [SYM_W-1:0] GCR_CODE [16] = '{
		5'h0A, 5'h0B, 5'h12, 5'h13, 5'h0E, 5'h0F, 5'h16, 5'h17,
		5'h09, 5'h19, 5'h1A, 5'h1B, 5'h0D, 5'h1D, 5'h1E, 5'h15
	};

	// invalid codes fall through to 0
	function automatic logic [NYB_W-1:0] gcrDecode(input logic [SYM_W-1:0] code);
		logic [NYB_W-1:0] nyb;
		nyb = '0;
		for (int i = 0; i < 16; i++) begin
			if (GCR_CODE[i] == code)
				nyb = NYB_W'(i);
		end
		return nyb;
	endfunction

	function automatic logic [SYM_W-1:0] gcrEncode(input logic [NYB_W-1:0] nyb);
		return GCR_CODE[nyb];
	endfunction

endpackage

`default_nettype wire

// ==== gcrRouterRx.f ====
common/gcrRxPkg.sv
rxFrame/sampleCounter.sv
rxFrame/gcrDeframer.sv
rxFrame/rxFrameFsm.sv
hdl/frameFifo.sv
hdl/busReadPort.sv
hdl/gcrRouterRx.sv
tb/gcrRouterRxTb.sv

// ==== hdl/busReadPort.sv ====
`timescale 1ns/100ps
`default_nettype none

module busReadPort (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic cs_i,
	input wire logic we_i,		// writes acked, otherwise ignored
	output logic ack_o,
	output logic popEn_o
);
	import gcrRxPkg::*;

	logic sel;
	logic readSel;
	logic readSelQ;
	logic [ACK_DELAY-1:0] rdy;	// ready chain, one stage per held clock

	assign sel = cyc_i && stb_i && cs_i;
	assign readSel = sel && !we_i;

	// ====================
	// ack delay, any drop of the select restarts it
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdy <= '0;
			readSelQ <= 1'b0;
		end else begin
			rdy[0] <= sel;
			for (int i = 1; i < ACK_DELAY; i++)
				rdy[i] <= rdy[i-1] && sel;
			readSelQ <= readSel;
		end
	end

	assign ack_o = sel && rdy[ACK_DELAY-1];
	assign popEn_o = readSel && !readSelQ;	// rising edge of a read select

	// ack only at the end of an unbroken run of select
	assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> sel && $past(sel) && $past(sel, 2) && $past(sel, 3));

endmodule

`default_nettype wire

// ==== hdl/frameFifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module frameFifo (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic wrEn_i,
	input wire logic popEn_i,
	input wire logic [gcrRxPkg::WORD_W-1:0] wrData_i,
	output logic [gcrRxPkg::WORD_W-1:0] rdData_o,
	output logic [gcrRxPkg::FIFO_CNT_W-1:0] count_o
);
	import gcrRxPkg::*;

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_CNT_W-1:0] wrPtr;	// wraps at depth
	logic [FIFO_CNT_W-1:0] rdPtr;
	logic doPop;
	logic full;

	assign doPop = popEn_i && (count_o != '0);	// empty pop is ignored
	// count saturates one short of the depth
	assign full = (count_o == '1);

	// ====================
	// storage and output register
	always_ff @(posedge clk_i) begin
		if (wrEn_i)
			mem[wrPtr] <= wrData_i;
		if (doPop)
			rdData_o <= mem[rdPtr];	// held until next pop
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count_o <= '0;
		end else begin
			if (wrEn_i)
				wrPtr <= wrPtr + FIFO_CNT_W'(1);
			if (doPop)
				rdPtr <= rdPtr + FIFO_CNT_W'(1);
			case ({wrEn_i, doPop})
				2'b10: count_o <= count_o + FIFO_CNT_W'(1);
				2'b01: count_o <= count_o - FIFO_CNT_W'(1);
				default: count_o <= count_o;	// none, or both
			endcase
		end
	end

	assert property (@(posedge clk_i) disable iff (rst_i)
		wrEn_i |-> !full);

endmodule

`default_nettype wire

// ==== hdl/gcrRouterRx.sv ====
`timescale 1ns/100ps
`default_nettype none

module gcrRouterRx (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic cs_i,
	input wire logic we_i,
	input wire logic baudCe_i,
	input wire logic clear_i,
	input wire logic [gcrRxPkg::SYM_W-1:0] rxd_i,
	output logic ack_o,
	output logic frameErr_o,
	output logic overrun_o,
	output logic [gcrRxPkg::WORD_W-1:0] dat_o,
	output logic [gcrRxPkg::FIFO_CNT_W-1:0] fifoCount_o
);
	import gcrRxPkg::*;

	logic [SYM_W-1:0] symSync;
	logic [WORD_W-1:0] payload;
	logic [CNT_W-1:0] tickCount;
	logic [FIFO_CNT_W-1:0] fifoCount;
	logic frameActive;
	logic shiftEn;
	logic wrEn;
	logic popEn;

	assign fifoCount_o = fifoCount;

	// ====================
	// receive path
	gcrDeframer uDeframer (
		.clk_i(clk_i),
		.rxd_i(rxd_i),
		.shiftEn_i(shiftEn),
		.symSync_o(symSync),
		.payload_o(payload)
	);

	sampleCounter uCounter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.baudCe_i(baudCe_i),
		.frameActive_i(frameActive),
		.tickCount_o(tickCount)
	);

	rxFrameFsm uFsm (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.baudCe_i(baudCe_i),
		.clear_i(clear_i),
		.symSync_i(symSync),
		.tickCount_i(tickCount),
		.fifoCount_i(fifoCount),
		.frameActive_o(frameActive),
		.shiftEn_o(shiftEn),
		.wrEn_o(wrEn),
		.frameErr_o(frameErr_o),
		.overrun_o(overrun_o)
	);

	// ====================
	// buffer and bus side
	frameFifo uFifo (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wrEn_i(wrEn),
		.popEn_i(popEn),
		.wrData_i(payload),
		.rdData_o(dat_o),
		.count_o(fifoCount)
	);

	busReadPort uBus (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.cs_i(cs_i),
		.we_i(we_i),
		.ack_o(ack_o),
		.popEn_o(popEn)
	);

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then search the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module gcrRouterRxTb \
	-f gcrRouterRx.f -o gcrRouterRxSim \
	&& ./obj_dir/gcrRouterRxSim > sim.log 2>&1 \
	|| { echo "build or run failed"; [ -f sim.log ] && cat sim.log; exit 1; }
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// ==== rxFrame/gcrDeframer.sv ====
`timescale 1ns/100ps
`default_nettype none

module gcrDeframer (
	input wire logic clk_i,
	input wire logic [gcrRxPkg::SYM_W-1:0] rxd_i,	// raw line, async
	input wire logic shiftEn_i,
	output logic [gcrRxPkg::SYM_W-1:0] symSync_o,
	output logic [gcrRxPkg::WORD_W-1:0] payload_o
);
	import gcrRxPkg::*;

	logic [SYM_W-1:0] syncReg [SYNC_STAGES];		// synchronizer stages
	logic [FRAME_SYMS*NYB_W-1:0] shiftReg;		// whole frame, oldest symbol at bottom

	// ====================
	// line synchronizer
	always_ff @(posedge clk_i) begin
		syncReg[0] <= rxd_i;
		for (int i = 1; i < SYNC_STAGES; i++)
			syncReg[i] <= syncReg[i-1];
	end

	assign symSync_o = syncReg[SYNC_STAGES-1];

	// ====================
	// decode and shift in at the top, older nybbles move down
	always_ff @(posedge clk_i) begin
		if (shiftEn_i)
			shiftReg <= {gcrDecode(symSync_o), shiftReg[FRAME_SYMS*NYB_W-1:NYB_W]};
	end

	// after 36 shifts: start and spare in the low two nybbles,
	// spare and stop in the top two
	assign payload_o = shiftReg[2*NYB_W +: WORD_W];

endmodule

`default_nettype wire

// ==== rxFrame/rxFrameFsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module rxFrameFsm (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic baudCe_i,		// baud clock enable
	input wire logic clear_i,		// abort frame, drop overrun
	input wire logic [gcrRxPkg::SYM_W-1:0] symSync_i,
	input wire logic [gcrRxPkg::CNT_W-1:0] tickCount_i,
	input wire logic [gcrRxPkg::FIFO_CNT_W-1:0] fifoCount_i,
	output logic frameActive_o,
	output logic shiftEn_o,
	output logic wrEn_o,
	output logic frameErr_o,
	output logic overrun_o
);
	import gcrRxPkg::*;

	rxState_e state;
	logic confirmTick;	// start code check point
	logic endTick;
	logic lastTick;
	logic falseStart;

	// ====================
	// tick count decode
	assign confirmTick = (tickCount_i == CNT_W'(1));
	assign endTick = (tickCount_i == END_TICK);
	assign lastTick = (tickCount_i == LAST_TICK);
	assign falseStart = confirmTick && (symSync_i != START_SYM);

	assign frameActive_o = (state == RX_COUNT);
	// one sample per symbol, at phase 1 of its four ticks
	assign shiftEn_o = baudCe_i && !clear_i && (state == RX_COUNT)
		&& (tickCount_i[1:0] == SAMPLE_PHASE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= RX_IDLE;
			wrEn_o <= 1'b0;
			frameErr_o <= 1'b0;
			overrun_o <= 1'b0;
		end else begin
			wrEn_o <= 1'b0;	// single clock pulse
			if (clear_i) begin
				state <= RX_IDLE;
				overrun_o <= 1'b0;
			end else if (baudCe_i) begin
				case (state)
					RX_IDLE: begin
						if (symSync_i == START_SYM)
							state <= RX_COUNT;
					end
					RX_COUNT: begin
						// end of frame: judge stop code, store or refuse the word
						if (endTick) begin
							frameErr_o <= (symSync_i != STOP_SYM);
							if (fifoCount_i < FIFO_LIMIT)
								wrEn_o <= 1'b1;
							else
								overrun_o <= 1'b1;	// sticky until clear
						end
						if (lastTick || falseStart)
							state <= RX_IDLE;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// ====================
	// fifo count is owned by frameFifo, the limit check spans both blocks
	assert property (@(posedge clk_i) disable iff (rst_i)
		wrEn_o |-> (fifoCount_i < FIFO_LIMIT));

	// sampling only inside a frame, and never past its last tick
	assert property (@(posedge clk_i) disable iff (rst_i)
		shiftEn_o |-> (state == RX_COUNT) && (tickCount_i <= LAST_TICK));

endmodule

`default_nettype wire

// ==== rxFrame/sampleCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module sampleCounter (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic baudCe_i,
	input wire logic frameActive_i,
	output logic [gcrRxPkg::CNT_W-1:0] tickCount_o
);
	import gcrRxPkg::*;

	// count advances on baud ticks only, held in between
	always_ff @(posedge clk_i) begin
		if (rst_i)
			tickCount_o <= '0;
		else if (baudCe_i) begin
			if (frameActive_i && (tickCount_o != LAST_TICK))
				tickCount_o <= tickCount_o + CNT_W'(1);
			else
				tickCount_o <= '0;	// idle, or wrap at frame end
		end
	end

	assert property (@(posedge clk_i) disable iff (rst_i)
		tickCount_o <= LAST_TICK);

endmodule

`default_nettype wire

// ==== tb/gcrRouterRxTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module gcrRouterRxTb;
	import gcrRxPkg::*;

	typedef logic [NYB_W-1:0] nybArr_t [32];

	localparam int FRAMES_SENT = 45;	// 8 + 2 + 1 + 32 + 2
	localparam int TICK_NS = 40;		// one baud tick every 4 clocks
	localparam int MARGIN_NS = 50000;
	localparam int ACK_WAIT = 20;
	localparam logic [SYM_W-1:0] IDLE_SYM = 5'h00;
	localparam logic [SYM_W-1:0] BAD_STOP = 5'h1F;	// not a valid code

	logic clk_i;
	logic rst_i;
	logic cyc_i;
	logic stb_i;
	logic cs_i;
	logic we_i;
	logic baudCe_i;
	logic clear_i;
	logic [SYM_W-1:0] rxd_i;
	logic ack_o;
	logic frameErr_o;
	logic overrun_o;
	logic [WORD_W-1:0] dat_o;
	logic [FIFO_CNT_W-1:0] fifoCount_o;

	logic [WORD_W-1:0] expQ [$];	// fifo model
	logic [WORD_W-1:0] expRead;		// word the last pop should show
	logic expOverrun = 1'b0;
	nybArr_t sentNyb;
	logic [31:0] rngState = 32'd64331;
	logic [1:0] baudDiv;
	string testName = "reset";
	int errCount = 0;
	int testErrStart = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int checksDone = 0;

	gcrRouterRx uut (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.cs_i(cs_i),
		.we_i(we_i),
		.baudCe_i(baudCe_i),
		.clear_i(clear_i),
		.rxd_i(rxd_i),
		.ack_o(ack_o),
		.frameErr_o(frameErr_o),
		.overrun_o(overrun_o),
		.dat_o(dat_o),
		.fifoCount_o(fifoCount_o)
	);

	// ====================
	// clock, baud enable, watchdog
	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	initial begin
		baudCe_i = 1'b0;
		baudDiv = '0;
		forever begin
			@(posedge clk_i);
			#1;
			baudDiv = baudDiv + 2'd1;
			baudCe_i = (baudDiv == 2'd0);	// every 4th clock
		end
	end

	initial begin
		#(FRAMES_SENT * 150 * TICK_NS + MARGIN_NS);
		$display("watchdog expired in test %s, run did not complete", testName);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ====================
	// reference model
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [WORD_W-1:0] expectedWord(input nybArr_t nyb);
		logic [WORD_W-1:0] w;
		w = '0;
		for (int i = 0; i < 32; i++)
			w[NYB_W*i +: NYB_W] = nyb[i];	// first payload symbol lands lowest
		return w;
	endfunction

	task automatic nextWord(output logic [WORD_W-1:0] w);
		for (int i = 0; i < 4; i++) begin
			rngState = xorshift32(rngState);
			w[32*i +: 32] = rngState;
		end
	endtask

	task automatic checkValue(input string what, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		checksDone++;
		assert (exp === act) else begin
			$display("MISMATCH %s %s: expected %0h, actual %0h", testName, what, exp, act);
			errCount++;
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrStart = errCount;
	endtask

	task automatic endTest();
		testsRun++;
		if (errCount != testErrStart)
			testsFailed++;
		$display("test %s %s", testName, (errCount == testErrStart) ? "ok" : "FAILED");
	endtask

	// ====================
	// line side
	task automatic waitTicks(input int n);
		repeat (n) begin
			@(posedge clk_i);
			while (!baudCe_i)
				@(posedge clk_i);
		end
	endtask

	// called just after a tick edge
	task automatic sendSym(input logic [SYM_W-1:0] sym, input int ticks);
		#1;
		rxd_i = sym;
		waitTicks(ticks);
	endtask

	task automatic sendFrame(input logic [WORD_W-1:0] word, input logic [SYM_W-1:0] stopSym);
		for (int i = 0; i < 32; i++)
			sentNyb[i] = word[NYB_W*i +: NYB_W];
		waitTicks(1);
		sendSym(START_SYM, 4);
		sendSym(gcrEncode(4'h5), 4);	// spare
		for (int i = 0; i < 32; i++)
			sendSym(gcrEncode(sentNyb[i]), 4);
		sendSym(gcrEncode(4'h5), 4);
		sendSym(stopSym, 4);
		sendSym(IDLE_SYM, 4);	// gap, fsm back in idle
		if (expQ.size() < int'(FIFO_LIMIT))
			expQ.push_back(expectedWord(sentNyb));
		else
			expOverrun = 1'b1;	// frame refused
		checkValue("frameErr_o", 128'(stopSym != STOP_SYM), 128'(frameErr_o));
		checkValue("overrun_o", 128'(expOverrun), 128'(overrun_o));
		checkValue("fifoCount_o", 128'(expQ.size()), 128'(fifoCount_o));
	endtask

	// ====================
	// bus side
	task automatic busAccess(input logic write, input int holdClocks);
		int waited;
		waited = 0;
		@(posedge clk_i);
		#1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		cs_i = 1'b1;
		we_i = write;
		if (!write && (expQ.size() > 0))
			expRead = expQ.pop_front();	// empty pop keeps the old word
		// ack looked at just after each edge, chain settled by then
		do begin
			@(posedge clk_i);
			#1;
			waited++;
		end while (!ack_o && (waited < ACK_WAIT));
		assert (ack_o) else begin
			$display("%s: no ack within %0d clocks of the select", testName, ACK_WAIT);
			errCount++;
		end
		checkValue("ack delay", 128'(ACK_DELAY), 128'(waited));
		repeat (holdClocks + 1) @(posedge clk_i);
		#1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		cs_i = 1'b0;
		we_i = 1'b0;
		checkValue("fifoCount_o", 128'(expQ.size()), 128'(fifoCount_o));
	endtask

	task automatic drainFifo();
		while (expQ.size() > 0)
			busAccess(1'b0, 0);
	endtask

	// read data on every read ack, and no ack without a select
	always @(negedge clk_i) begin
		assert (!ack_o || (cyc_i && stb_i && cs_i)) else begin
			$display("%s: ack_o high while the select is low", testName);
			errCount++;
		end
		if (ack_o && !we_i) begin
			checksDone++;
			assert (dat_o === expRead) else begin
				$display("MISMATCH %s dat_o: expected %0h, actual %0h", testName, expRead, dat_o);
				errCount++;
			end
		end
	end

	// ====================
	// test sequence
	initial begin
		logic [WORD_W-1:0] w;
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		cs_i = 1'b0;
		we_i = 1'b0;
		clear_i = 1'b0;
		rxd_i = IDLE_SYM;
		expRead = '0;
		repeat (5) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		beginTest("cleanFrames");
		for (int i = 0; i < 8; i++) begin
			nextWord(w);
			sendFrame(w, STOP_SYM);
		end
		drainFifo();
		endTest();

		beginTest("framingErr");
		nextWord(w);
		sendFrame(w, BAD_STOP);	// word still stored
		nextWord(w);
		sendFrame(w, STOP_SYM);
		drainFifo();
		endTest();

		beginTest("falseStart");
		waitTicks(1);
		sendSym(START_SYM, 1);	// seen at one tick only
		sendSym(IDLE_SYM, 12);
		checkValue("fifoCount_o", 128'(expQ.size()), 128'(fifoCount_o));
		nextWord(w);
		sendFrame(w, STOP_SYM);
		drainFifo();
		endTest();

		beginTest("overrun");
		for (int i = 0; i < 32; i++) begin
			nextWord(w);
			sendFrame(w, STOP_SYM);
		end
		@(posedge clk_i);
		#1;
		clear_i = 1'b1;
		@(posedge clk_i);
		#1;
		clear_i = 1'b0;
		expOverrun = 1'b0;
		checkValue("overrun_o", 128'(expOverrun), 128'(overrun_o));
		drainFifo();
		endTest();

		beginTest("busPort");
		repeat (8) begin
			@(posedge clk_i);
			checkValue("ack_o idle", 128'(0), 128'(ack_o));
		end
		// two words, so a second pop would show in the count
		nextWord(w);
		sendFrame(w, STOP_SYM);
		nextWord(w);
		sendFrame(w, STOP_SYM);
		busAccess(1'b1, 4);		// write select, acked, no pop
		busAccess(1'b0, 10);	// long read select, one pop
		busAccess(1'b0, 0);		// last word
		busAccess(1'b0, 0);		// fifo empty now
		checkValue("dat_o held", expRead, dat_o);
		endTest();

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checksDone, errCount);
		if (errCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
